//--- rtl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // register file sizes
    localparam int arch_size = 32;
    localparam int phys_size = 64;
    localparam int reg_width = 32;

    localparam int arch_idx_width = $clog2(arch_size);
    localparam int phys_idx_width = $clog2(phys_size);

    typedef logic [arch_idx_width-1:0] arch_idx_t;
    typedef logic [phys_idx_width-1:0] phys_idx_t;
    typedef logic [reg_width-1:0]      reg_val_t;

    // one bit per physical register
    typedef logic [phys_size-1:0] phys_vec_t;

    // physical registers held by the identity map out of reset
    localparam phys_vec_t boot_alloc = phys_vec_t'({arch_size{1'b1}});

endpackage

`default_nettype wire

//--- rtl/arch_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module arch_map_table import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    input  wire            uop_update,
    input  wire arch_idx_t arch_rd1,
    input  wire arch_idx_t arch_rd2,
    input  wire arch_idx_t arch_wr,
    input  wire phys_idx_t arch_wr_phys,

    input  wire            rob_update,
    input  wire arch_idx_t arch_rob_update,
    input  wire phys_idx_t arch_rob_nonspec_phys,

    input  wire            rollback,

    output phys_idx_t      arch_rd1_phys,
    output phys_idx_t      arch_rd2_phys,
    output phys_idx_t      arch_wr_oldphys
);

    phys_idx_t spec_map [arch_size];
    phys_idx_t com_map  [arch_size];

    // sources see the mapping from before this edge
    assign arch_rd1_phys   = spec_map[arch_rd1];
    assign arch_rd2_phys   = spec_map[arch_rd2];
    assign arch_wr_oldphys = spec_map[arch_wr];

    // speculative map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_size; i++) begin
                spec_map[i] <= phys_idx_t'(i);
            end
        end else begin
            if (rollback) begin
                spec_map <= com_map;
            end else if (uop_update) begin
                spec_map[arch_wr] <= arch_wr_phys;
            end
        end
    end

    // committed map, written only by the rob
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_size; i++) begin
                com_map[i] <= phys_idx_t'(i);
            end
        end else begin
            if (rob_update) begin
                com_map[arch_rob_update] <= arch_rob_nonspec_phys;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    input  wire            alloc,

    input  wire            rob_update,
    input  wire phys_idx_t arch_rob_nonspec_phys,
    input  wire phys_idx_t phys_rob_free,

    input  wire            rollback,

    output phys_idx_t      next_free,
    output logic           none_free
);

    phys_vec_t spec_free;
    phys_vec_t com_free;

    // lowest set bit wins, so scan from the top down
    always_comb begin
        next_free = '0;
        for (int i = phys_size - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                next_free = phys_idx_t'(i);
            end
        end
    end

    assign none_free = ~|spec_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_free <= ~boot_alloc;
        end else begin
            if (rollback) begin
                spec_free <= com_free;
            end else begin
                if (alloc) begin
                    spec_free[next_free] <= 1'b0;
                end
                if (rob_update) begin
                    spec_free[phys_rob_free] <= 1'b1;
                end
            end
        end
    end

    // retired register returns, committed mapping stays held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            com_free <= ~boot_alloc;
        end else if (rob_update) begin
            com_free[arch_rob_nonspec_phys] <= 1'b0;
            com_free[phys_rob_free]         <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    // stage 2
    input  wire            uop_update,
    input  wire phys_idx_t phys_rd1,
    input  wire phys_idx_t phys_rd2,
    input  wire phys_idx_t phys_wr,

    // stage 1 allocation
    input  wire            arch_update,

    input  wire            ring_update,
    input  wire phys_idx_t phys_ring,
    input  wire reg_val_t  phys_ring_val,

    input  wire            rob_update,
    input  wire phys_idx_t arch_rob_nonspec_phys,
    input  wire phys_idx_t phys_rob_free,

    input  wire            rollback,

    output logic           phys_rd1_rdy,
    output logic           phys_rd2_rdy,
    output reg_val_t       phys_rd1_val,
    output reg_val_t       phys_rd2_val,
    output logic           none_free,
    output phys_idx_t      next_free
);

    phys_vec_t ready;
    reg_val_t  vals [phys_size];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= boot_alloc;
            for (int i = 0; i < phys_size; i++) begin
                vals[i] <= '0;
            end
        end else begin
            // new destination waits for its result
            if (uop_update) begin
                ready[phys_wr] <= 1'b0;
            end
            if (ring_update) begin
                ready[phys_ring] <= 1'b1;
                vals[phys_ring]  <= phys_ring_val;
            end
        end
    end

    // no bypass, reads see the array before this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phys_rd1_rdy <= 1'b1;
            phys_rd2_rdy <= 1'b1;
            phys_rd1_val <= '0;
            phys_rd2_val <= '0;
        end else begin
            phys_rd1_rdy <= ready[phys_rd1];
            phys_rd2_rdy <= ready[phys_rd2];
            phys_rd1_val <= vals[phys_rd1];
            phys_rd2_val <= vals[phys_rd2];
        end
    end

    free_list fl (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .alloc                 (arch_update),
        .rob_update            (rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .phys_rob_free         (phys_rob_free),
        .rollback              (rollback),
        .next_free             (next_free),
        .none_free             (none_free)
    );

endmodule

`default_nettype wire

//--- rtl/rename_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rename_regfile import rename_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,

    input  wire            uop_update,
    input  wire arch_idx_t arch_rd1,
    input  wire arch_idx_t arch_rd2,
    input  wire arch_idx_t arch_wr,

    input  wire            ring_update,
    input  wire phys_idx_t phys_ring,
    input  wire reg_val_t  phys_ring_val,

    input  wire            rob_update,
    input  wire arch_idx_t arch_rob_update,
    input  wire phys_idx_t arch_rob_nonspec_phys,
    input  wire phys_idx_t phys_rob_free,

    input  wire            rollback,

    output logic           phys_rd1_rdy,
    output logic           phys_rd2_rdy,
    output phys_idx_t      phys_rd1,
    output phys_idx_t      phys_rd2,
    output phys_idx_t      phys_wr,
    output phys_idx_t      oldphys_wr,
    output reg_val_t       phys_rd1_val,
    output reg_val_t       phys_rd2_val,
    output logic           none_free
);

    phys_idx_t next_free;
    phys_idx_t map_rd1;
    phys_idx_t map_rd2;
    phys_idx_t map_old;

    // stage 1 results
    logic      upd_s1;
    phys_idx_t rd1_s1;
    phys_idx_t rd2_s1;
    phys_idx_t wr_s1;
    phys_idx_t old_s1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_s1     <= 1'b0;
            rd1_s1     <= '0;
            rd2_s1     <= '0;
            wr_s1      <= '0;
            old_s1     <= '0;
            phys_rd1   <= '0;
            phys_rd2   <= '0;
            phys_wr    <= '0;
            oldphys_wr <= '0;
        end else begin
            // a rollback squashes the pending ready clear
            upd_s1     <= uop_update & ~rollback;
            rd1_s1     <= map_rd1;
            rd2_s1     <= map_rd2;
            wr_s1      <= next_free;
            old_s1     <= map_old;
            // stage 2
            phys_rd1   <= rd1_s1;
            phys_rd2   <= rd2_s1;
            phys_wr    <= wr_s1;
            oldphys_wr <= old_s1;
        end
    end

    arch_map_table amt (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .uop_update            (uop_update),
        .arch_rd1              (arch_rd1),
        .arch_rd2              (arch_rd2),
        .arch_wr               (arch_wr),
        .arch_wr_phys          (next_free),
        .rob_update            (rob_update),
        .arch_rob_update       (arch_rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .rollback              (rollback),
        .arch_rd1_phys         (map_rd1),
        .arch_rd2_phys         (map_rd2),
        .arch_wr_oldphys       (map_old)
    );

    phys_regfile prf (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .uop_update            (upd_s1),
        .phys_rd1              (rd1_s1),
        .phys_rd2              (rd2_s1),
        .phys_wr               (wr_s1),
        .arch_update           (uop_update),
        .ring_update           (ring_update),
        .phys_ring             (phys_ring),
        .phys_ring_val         (phys_ring_val),
        .rob_update            (rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .phys_rob_free         (phys_rob_free),
        .rollback              (rollback),
        .phys_rd1_rdy          (phys_rd1_rdy),
        .phys_rd2_rdy          (phys_rd2_rdy),
        .phys_rd1_val          (phys_rd1_val),
        .phys_rd2_val          (phys_rd2_val),
        .none_free             (none_free),
        .next_free             (next_free)
    );

endmodule

`default_nettype wire

//--- verification/tb_rename_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_regfile import rename_pkg::*; ();

    localparam int words_per_line = 15;
    localparam int max_lines      = 96;
    localparam int reset_cycles   = 16;

    logic      clk;
    logic      rst_n;
    logic      uop_update;
    arch_idx_t arch_rd1;
    arch_idx_t arch_rd2;
    arch_idx_t arch_wr;
    logic      ring_update;
    phys_idx_t phys_ring;
    reg_val_t  phys_ring_val;
    logic      rob_update;
    arch_idx_t arch_rob_update;
    phys_idx_t arch_rob_nonspec_phys;
    phys_idx_t phys_rob_free;
    logic      rollback;

    logic      phys_rd1_rdy;
    logic      phys_rd2_rdy;
    phys_idx_t phys_rd1;
    phys_idx_t phys_rd2;
    phys_idx_t phys_wr;
    phys_idx_t oldphys_wr;
    reg_val_t  phys_rd1_val;
    reg_val_t  phys_rd2_val;
    logic      none_free;

    logic [31:0] pat [words_per_line*max_lines];
    int line_count;
    int cycle_limit = 100000;
    int cycles = 0;
    int tick = 0;
    int cur_test;
    int test_errs = 0;
    int total_errs = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // pattern line of each request in flight, and the tick its outputs are due
    int pend_line [$];
    int pend_due  [$];

    rename_regfile uut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .uop_update            (uop_update),
        .arch_rd1              (arch_rd1),
        .arch_rd2              (arch_rd2),
        .arch_wr               (arch_wr),
        .ring_update           (ring_update),
        .phys_ring             (phys_ring),
        .phys_ring_val         (phys_ring_val),
        .rob_update            (rob_update),
        .arch_rob_update       (arch_rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .phys_rob_free         (phys_rob_free),
        .rollback              (rollback),
        .phys_rd1_rdy          (phys_rd1_rdy),
        .phys_rd2_rdy          (phys_rd2_rdy),
        .phys_rd1              (phys_rd1),
        .phys_rd2              (phys_rd2),
        .phys_wr               (phys_wr),
        .oldphys_wr            (oldphys_wr),
        .phys_rd1_val          (phys_rd1_val),
        .phys_rd2_val          (phys_rd2_val),
        .none_free             (none_free)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT run did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int ln, input int k);
        return pat[ln*words_per_line + k];
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL time %0t test %0d %s got %0h expected %0h",
                     $time, cur_test, name, got, exp);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic check_request(input int ln);
        check_field("phys_rd1", 32'(phys_rd1), field(ln, 6));
        check_field("phys_rd2", 32'(phys_rd2), field(ln, 7));
        check_field("phys_wr", 32'(phys_wr), field(ln, 8));
        check_field("oldphys_wr", 32'(oldphys_wr), field(ln, 9));
        check_field("phys_rd1_rdy", 32'(phys_rd1_rdy), field(ln, 10));
        check_field("phys_rd2_rdy", 32'(phys_rd2_rdy), field(ln, 11));
        check_field("phys_rd1_val", phys_rd1_val, field(ln, 12));
        check_field("phys_rd2_val", phys_rd2_val, field(ln, 13));
    endtask

    task automatic drive_idle();
        uop_update            = 1'b0;
        arch_rd1              = '0;
        arch_rd2              = '0;
        arch_wr               = '0;
        ring_update           = 1'b0;
        phys_ring             = '0;
        phys_ring_val         = '0;
        rob_update            = 1'b0;
        arch_rob_update       = '0;
        arch_rob_nonspec_phys = '0;
        phys_rob_free         = '0;
        rollback              = 1'b0;
    endtask

    task automatic drive_line(input int ln);
        logic [31:0] op;
        op = field(ln, 1);
        drive_idle();
        case (op)
            32'd1: begin
                uop_update = 1'b1;
                arch_rd1   = arch_idx_t'(field(ln, 2));
                arch_rd2   = arch_idx_t'(field(ln, 3));
                arch_wr    = arch_idx_t'(field(ln, 4));
                pend_line.push_back(ln);
                pend_due.push_back(tick + 2);
            end
            32'd2: begin
                ring_update   = 1'b1;
                phys_ring     = phys_idx_t'(field(ln, 2));
                phys_ring_val = field(ln, 5);
            end
            32'd3: begin
                rob_update            = 1'b1;
                arch_rob_update       = arch_idx_t'(field(ln, 2));
                arch_rob_nonspec_phys = phys_idx_t'(field(ln, 3));
                phys_rob_free         = phys_idx_t'(field(ln, 4));
            end
            32'd4: rollback = 1'b1;
            default: ;
        endcase
    endtask

    // falling edge, then check the requests whose outputs are due now
    task automatic next_cycle();
        int ln;
        @(negedge clk);
        tick++;
        while (pend_due.size() > 0 && pend_due[0] == tick) begin
            ln = pend_line[0];
            pend_line.delete(0);
            pend_due.delete(0);
            check_request(ln);
        end
    endtask

    task automatic drain();
        while (pend_line.size() > 0) begin
            next_cycle();
            drive_idle();
        end
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        drive_idle();
        rst_n = 1'b0;
        $readmemh("verification/rename_patterns.txt", pat);
        line_count = 0;
        while (line_count < max_lines && field(line_count, 0) != 0) begin
            line_count++;
        end
        cycle_limit = reset_cycles + line_count + 20;
        cur_test = field(0, 0);
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        for (int ln = 0; ln < line_count; ln++) begin
            if (field(ln, 0) != cur_test) begin
                drain();
                report_test();
                cur_test = field(ln, 0);
            end
            next_cycle();
            check_field("none_free", 32'(none_free), field(ln, 14));
            drive_line(ln);
        end
        drain();
        if (line_count > 0) begin
            report_test();
        end else begin
            $display("no pattern lines were loaded from the patterns file");
            total_errs++;
        end

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rename_patterns.txt
// columns are test, op, a, b, c, d, then expected phys_rd1 phys_rd2 phys_wr oldphys_wr
// rdy1 rdy2 val1 val2 none_free; op 1 request, 2 ring, 3 commit, 4 rollback, 0 idle
// request a b c = rd1 rd2 wr, ring a d = reg value, commit a b c = arch nonspec freed
01 1 03 07 05 00000000 03 07 20 05 1 1 00000000 00000000 0
// back to back renames of arch 9
02 1 01 02 09 00000000 01 02 21 09 1 1 00000000 00000000 0
02 1 01 02 09 00000000 01 02 22 21 1 1 00000000 00000000 0
02 1 09 05 0a 00000000 22 20 23 0a 0 0 00000000 00000000 0
// ring writebacks then a read
03 2 22 00 00 deadbeef 00 00 00 00 0 0 00000000 00000000 0
03 2 20 00 00 12345678 00 00 00 00 0 0 00000000 00000000 0
03 1 09 05 0b 00000000 22 20 24 0b 1 1 deadbeef 12345678 0
// commits in order, freeing 5 first
04 3 05 20 05 00000000 00 00 00 00 0 0 00000000 00000000 0
04 3 09 21 09 00000000 00 00 00 00 0 0 00000000 00000000 0
04 3 09 22 21 00000000 00 00 00 00 0 0 00000000 00000000 0
04 3 0a 23 0a 00000000 00 00 00 00 0 0 00000000 00000000 0
04 3 0b 24 0b 00000000 00 00 00 00 0 0 00000000 00000000 0
04 1 05 09 0c 00000000 20 22 05 0c 1 1 12345678 deadbeef 0
04 1 0c 0c 0d 00000000 05 05 09 0d 0 0 00000000 00000000 0
// rollback to the committed state
05 1 00 00 05 00000000 00 00 0a 20 1 1 00000000 00000000 0
05 1 05 01 09 00000000 0a 01 0b 22 0 1 00000000 00000000 0
05 4 00 00 00 00000000 00 00 00 00 0 0 00000000 00000000 0
05 1 05 09 0e 00000000 20 22 05 0e 1 1 12345678 deadbeef 0
05 1 0c 0d 0f 00000000 0c 0d 09 0f 1 1 00000000 00000000 0
// exhaust the free list through arch 20
06 1 01 02 14 00000000 01 02 0a 14 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 0b 0a 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 21 0b 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 25 21 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 26 25 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 27 26 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 28 27 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 29 28 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2a 29 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2b 2a 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2c 2b 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2d 2c 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2e 2d 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 2f 2e 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 30 2f 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 31 30 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 32 31 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 33 32 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 34 33 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 35 34 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 36 35 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 37 36 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 38 37 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 39 38 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3a 39 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3b 3a 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3c 3b 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3d 3c 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3e 3d 1 1 00000000 00000000 0
06 1 01 02 14 00000000 01 02 3f 3e 1 1 00000000 00000000 0
// list empty, a commit hands back phys 20
06 3 14 0a 14 00000000 00 00 00 00 0 0 00000000 00000000 1
06 1 14 01 15 00000000 3f 01 14 15 0 1 00000000 00000000 0
// end marker
00 0 00 00 00 00000000 00 00 00 00 0 0 00000000 00000000 0

//--- sim.f
rtl/rename_pkg.sv
rtl/arch_map_table.sv
rtl/free_list.sv
rtl/phys_regfile.sv
rtl/rename_regfile.sv
verification/tb_rename_regfile.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= tb_rename_regfile
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
